/* src.f */
bubl_pkg.sv
bubl_main_decode.sv
bubl_ctrl_regs.sv
bubl_cabinet.sv
bubl_work_ram.sv
bubl_main_board.sv
tb_bubl_checker.sv
tb_bubl.sv

/* Bender.yml */
package:
  name: bubl_main_board

sources:
  - files:
      - bubl_pkg.sv
      - bubl_main_decode.sv
      - bubl_ctrl_regs.sv
      - bubl_cabinet.sv
      - bubl_work_ram.sv
      - bubl_main_board.sv
  - target: simulation
    files:
      - tb_bubl_checker.sv
      - tb_bubl.sv

/* bubl_stimulus.txt */
# op game we addr data exp delay test (op 0 main, 1 sub, 2 main+sub write, 3 misc, 4 sound, 5 flag, 6 main_stb, 7 nmi)
# addr/data/exp hex; op 2 exp is the sub address with data inverted; op 4 exp {rstn,latch}, data strobe cycles
3 0 0 0000 00 00 0 1
4 0 0 0000 00 100 0 1
5 0 0 0000 00 1 0 1
7 0 0 0000 00 0 0 1
0 0 1 E010 A5 00 0 2
1 0 0 E010 00 A5 0 2
0 1 1 E020 3C 00 0 2
1 1 0 8020 00 3C 0 2
0 1 0 E010 00 A5 0 2
2 1 1 E100 11 8200 0 3
0 1 0 E200 00 EE 0 3
1 1 0 8100 00 11 0 3
0 0 1 FB40 41 00 0 4
3 0 0 0000 00 2C 0 4
0 0 0 8123 00 53 3 4
0 0 0 1234 00 30 0 4
0 1 1 FA80 43 00 0 4
3 1 0 0000 00 1D 0 4
0 1 0 A456 00 0F 5 4
0 0 1 FA00 5A 00 0 5
4 0 0 0000 01 15A 0 5
0 0 1 FA03 01 00 0 5
4 0 0 0000 00 05A 0 5
0 0 1 FA03 00 00 0 5
4 0 0 0000 00 15A 0 5
0 0 0 FA01 00 FE 0 5
5 0 0 0000 00 0 0 5
0 0 0 FA01 00 FC 0 5
6 0 0 0000 00 0 0 5
5 0 0 0000 00 1 0 5
0 0 0 FA00 00 96 0 5
0 0 1 FB40 D0 00 0 6
3 0 0 0000 00 27 0 6
0 0 1 FB40 00 00 0 6
3 0 0 0000 00 20 0 6
0 1 1 FA80 00 00 0 6
3 1 0 0000 00 01 0 6
0 1 1 FB00 80 00 0 6
3 1 0 0000 00 03 0 6
0 1 1 FB80 00 00 0 6
7 1 0 0000 00 1 0 6
0 0 1 FB00 00 00 0 6
7 0 0 0000 00 1 0 6
0 1 0 FA03 00 5C 0 7
0 1 0 FA04 00 A3 0 7
0 1 0 FA05 00 FB 0 7
0 1 0 FA06 00 D9 0 7
0 1 0 FA07 00 A3 0 7
0 0 0 FB40 00 FF 0 7
0 0 0 FC00 00 FF 0 7
0 1 0 FE00 00 BF 0 7
1 1 0 C000 00 FF 0 7

/* tb_bubl.sv */
//////////////////////////////////////////////////////////////////////
// Testbench top: clock, reset, ROM model, stimulus reader, bus driver
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_bubl
    import bubl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_LIMIT = 60;     // Cycles before a missing ack counts as a hang

    logic        clk24;
    logic        rst;
    game_t       game;
    wb_req_t     main_bus;
    wb_req_t     sub_bus;
    wb_rsp_t     main_rsp;
    wb_rsp_t     sub_rsp;
    logic [17:0] main_rom_addr;
    logic        main_rom_cs;
    logic        main_rom_ok;
    logic [7:0]  main_rom_data;
    logic        vram_cs;
    logic        pal_cs;
    logic        cpu_we;
    logic [7:0]  vram_dout;
    logic [7:0]  pal_dout;
    snd_t        snd;
    logic        main_flag;
    logic [7:0]  main_latch;
    logic        snd_flag;
    logic        main_stb;
    misc_t       misc;
    logic        nmi_sub;
    cab_in_t     cab;

    int          kind;
    int          test_id;
    int          rom_delay;
    int          rom_cnt;
    logic        main_rd;
    logic        sub_rd;
    logic        check_now;
    logic        done;
    logic [15:0] exp_val;
    logic [7:0]  exp_aux;
    int          failed_tests;
    int          passed_tests;
    logic        timed_out;

    bubl_main_board #(.rom_aw(18), .work_aw(13)) u_dut (
        .clk24 (clk24), .rst (rst), .game (game),
        .main_bus (main_bus), .main_rsp (main_rsp),
        .sub_bus (sub_bus), .sub_rsp (sub_rsp),
        .main_rom_addr (main_rom_addr), .main_rom_cs (main_rom_cs),
        .main_rom_ok (main_rom_ok), .main_rom_data (main_rom_data),
        .vram_cs (vram_cs), .pal_cs (pal_cs), .cpu_we (cpu_we),
        .vram_dout (vram_dout), .pal_dout (pal_dout),
        .snd (snd), .main_flag (main_flag), .main_latch (main_latch),
        .snd_flag (snd_flag), .main_stb (main_stb),
        .misc (misc), .nmi_sub (nmi_sub), .cab (cab)
    );

    tb_bubl_checker u_chk (
        .clk24 (clk24), .rst (rst), .main_bus (main_bus),
        .main_rsp (main_rsp), .sub_rsp (sub_rsp),
        .main_rom_cs (main_rom_cs), .vram_cs (vram_cs), .pal_cs (pal_cs),
        .cpu_we (cpu_we), .misc (misc), .snd (snd),
        .main_flag (main_flag), .nmi_sub (nmi_sub),
        .kind (kind), .test_id (test_id), .rom_delay (rom_delay),
        .main_rd (main_rd), .sub_rd (sub_rd), .check_now (check_now), .done (done),
        .exp_val (exp_val), .exp_aux (exp_aux),
        .failed_tests (failed_tests), .passed_tests (passed_tests)
    );

    initial begin
        clk24 = 1'b0;
        forever #4 clk24 = ~clk24;
    end

    //////////////////////////////////////////////////////////////////
    // ROM model, ready once the select has been seen for delay cycles

    assign main_rom_data = main_rom_addr[7:0] ^ main_rom_addr[17:10];

    always @(posedge clk24)
        rom_cnt <= main_rom_cs ? rom_cnt + 1 : 0;

    always @(negedge clk24)
        main_rom_ok = rom_cnt > rom_delay;

    // Holds each request until its own ack, both ports at once if asked
    task automatic drive_access(input logic use_main, input logic use_sub,
                                input wb_req_t m_req, input wb_req_t s_req);
        int   cycles;
        logic m_wait;
        logic s_wait;
        logic m_done;
        logic s_done;
        m_wait = use_main;
        s_wait = use_sub;
        cycles = 0;
        if (use_main) begin
            main_bus = m_req;
            main_rd  = !m_req.we;
        end
        if (use_sub) begin
            sub_bus = s_req;
            sub_rd  = !s_req.we;
        end
        while ((m_wait || s_wait) && cycles < ACK_LIMIT) begin
            @(posedge clk24);
            m_done = m_wait && main_rsp.ack;
            s_done = s_wait && sub_rsp.ack;
            @(negedge clk24);
            if (m_done) begin
                main_bus = '0;
                main_rd  = 1'b0;
                m_wait   = 1'b0;
            end
            if (s_done) begin
                sub_bus = '0;
                sub_rd  = 1'b0;
                s_wait  = 1'b0;
            end
            cycles++;
        end
        if (m_wait || s_wait) begin
            $display("Timeout in test %0d: the %s port got no ack within %0d cycles",
                     test_id, m_wait ? "main" : "sub", ACK_LIMIT);
            timed_out = 1'b1;
            main_bus  = '0;
            sub_bus   = '0;
            main_rd   = 1'b0;
            sub_rd    = 1'b0;
        end
    endtask

    task automatic run_line(input int op, input int g, input int we, input logic [15:0] addr,
                            input logic [7:0] data, input logic [15:0] exp,
                            input int delay, input int tnum);
        wb_req_t req;
        wb_req_t sreq;
        @(negedge clk24);
        game      = game_t'(g);
        test_id   = tnum;
        kind      = op;
        exp_val   = exp;
        exp_aux   = data;
        rom_delay = delay;
        req  = '{cyc: 1'b1, stb: 1'b1, we: we[0], adr: addr, dat: data};
        sreq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: exp, dat: ~data};
        case (op)
            0: drive_access(1'b1, 1'b0, req, '0);
            1: drive_access(1'b0, 1'b1, '0, req);
            2: drive_access(1'b1, 1'b1, req, sreq);
            6: begin
                main_stb = 1'b1;
                repeat (2) @(negedge clk24);
                main_stb = 1'b0;
            end
            default: begin
                check_now = 1'b1;
                @(negedge clk24);
                check_now = 1'b0;
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          n;
        int          op;
        int          g;
        int          we;
        int          delay;
        int          tnum;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [15:0] exp;
        string       line;
        rst        = 1'b1;
        game       = game_bubble;
        main_bus   = '0;
        sub_bus    = '0;
        main_rom_ok = 1'b0;
        vram_dout  = 8'h00;
        pal_dout   = 8'h00;
        main_latch = 8'h96;
        snd_flag   = 1'b0;
        main_stb   = 1'b0;
        cab        = '{start: 2'b01, coin: 2'b10, joy1: 6'b101010, joy2: 6'b010011,
                       dip_a: 8'h5C, dip_b: 8'hA3};
        kind       = 0;
        test_id    = 0;
        rom_delay  = 0;
        rom_cnt    = 0;
        main_rd    = 1'b0;
        sub_rd     = 1'b0;
        check_now  = 1'b0;
        done       = 1'b0;
        exp_val    = '0;
        exp_aux    = '0;
        timed_out  = 1'b0;
        repeat (4) @(negedge clk24);
        rst = 1'b0;

        fd = $fopen("bubl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bubl_stimulus.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %h %h %h %d %d",
                                op, g, we, addr, data, exp, delay, tnum);
                    if (n == 8)
                        run_line(op, g, we, addr, data, exp, delay, tnum);
                end
            end
            $fclose(fd);
        end

        @(negedge clk24);
        done = 1'b1;
        repeat (2) @(negedge clk24);
        if (timed_out || fd == 0 || failed_tests != 0 || passed_tests == 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_bubl_checker.sv */
//////////////////////////////////////////////////////////////////////
// Testbench monitor, compares DUT responses and counts test results
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_bubl_checker
    import bubl_pkg::*;
(
    input  logic        clk24,
    input  logic        rst,
    input  wb_req_t     main_bus,
    input  wb_rsp_t     main_rsp,
    input  wb_rsp_t     sub_rsp,
    input  logic        main_rom_cs,
    input  logic        vram_cs,
    input  logic        pal_cs,
    input  logic        cpu_we,
    input  misc_t       misc,
    input  snd_t        snd,
    input  logic        main_flag,
    input  logic        nmi_sub,
    input  int          kind,           // Stimulus opcode of the current line
    input  int          test_id,
    input  int          rom_delay,
    input  logic        main_rd,
    input  logic        sub_rd,
    input  logic        check_now,
    input  logic        done,
    input  logic [15:0] exp_val,
    input  logic [7:0]  exp_aux,
    output int          failed_tests,
    output int          passed_tests
);
    timeunit 1ns;
    timeprecision 1ps;

    int   cur_test;
    int   cur_err;
    int   rom_cycles;
    int   stb_cnt;
    int   nmi_cnt;
    logic main_seen;
    logic finished;
    logic [3:0] exp_sel;

    task automatic report_error(input string msg);
        $display("FAIL %0t: test %0d %s", $time, cur_test, msg);
        cur_err++;
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            if (cur_err == 0) begin
                $display("PASS test %0d", cur_test);
                passed_tests++;
            end else begin
                $display("FAIL %0t: test %0d finished with %0d errors", $time, cur_test, cur_err);
                failed_tests++;
            end
        end
    endtask

    initial begin
        cur_test     = 0;
        cur_err      = 0;
        rom_cycles   = 0;
        stb_cnt      = 0;
        nmi_cnt      = 0;
        main_seen    = 1'b0;
        finished     = 1'b0;
        exp_sel      = '0;
        failed_tests = 0;
        passed_tests = 0;
    end

    //////////////////////////////////////////////////////////////////
    // Sampled on the rising edge, inputs settle at the falling edge

    always @(posedge clk24) begin
        if (!rst && !finished) begin
            if (test_id != cur_test) begin
                close_test();
                cur_test = test_id;
                cur_err  = 0;
            end
            if (main_rd && main_rsp.ack) begin
                if (main_rsp.dat !== exp_val[7:0])
                    report_error($sformatf("main read got %02h, expected %02h",
                                           main_rsp.dat, exp_val[7:0]));
                if (rom_delay > 0 && rom_cycles < rom_delay + 2)
                    report_error($sformatf("ROM ack after %0d cycles, ready delay %0d",
                                           rom_cycles, rom_delay));
            end
            if (sub_rd && sub_rsp.ack && sub_rsp.dat !== exp_val[7:0])
                report_error($sformatf("sub read got %02h, expected %02h",
                                       sub_rsp.dat, exp_val[7:0]));
            // Tie between ports goes to main
            if (kind == 2) begin
                if (sub_rsp.ack && !main_seen)
                    report_error("sub port acked before main port");
                if (main_rsp.ack)
                    main_seen = 1'b1;
            end else begin
                main_seen = 1'b0;
            end
            // ROM, VRAM and palette selects from the main-bus address map
            exp_sel = '0;
            if (main_bus.cyc && main_bus.stb)
                exp_sel = {main_bus.adr < 16'hC000,
                           main_bus.adr >= 16'hC000 && main_bus.adr < 16'hE000,
                           main_bus.adr >= 16'hF800 && main_bus.adr < 16'hFA00,
                           main_bus.we};
            if ({main_rom_cs, vram_cs, pal_cs, cpu_we} !== exp_sel)
                report_error($sformatf("rom/vram/pal/we selects %04b, expected %04b",
                                       {main_rom_cs, vram_cs, pal_cs, cpu_we}, exp_sel));
            if (check_now) begin
                case (kind)
                    3: if (misc !== exp_val[5:0])
                        report_error($sformatf("misc is %02h, expected %02h", misc, exp_val[5:0]));
                    4: begin
                        if ({snd.rstn, snd.latch} !== exp_val[8:0])
                            report_error($sformatf("sound rstn/latch %03h, expected %03h",
                                                   {snd.rstn, snd.latch}, exp_val[8:0]));
                        if (stb_cnt != exp_aux)
                            report_error($sformatf("sound strobe high %0d cycles, expected %0d",
                                                   stb_cnt, exp_aux));
                    end
                    5: if (main_flag !== exp_val[0])
                        report_error($sformatf("main_flag is %b, expected %b",
                                               main_flag, exp_val[0]));
                    7: if (nmi_cnt != exp_val)
                        report_error($sformatf("nmi_sub high %0d cycles, expected %0d",
                                               nmi_cnt, exp_val));
                    default: ;
                endcase
                if (kind == 4)
                    stb_cnt = 0;
                if (kind == 7)
                    nmi_cnt = 0;
            end
            rom_cycles = main_rom_cs ? rom_cycles + 1 : 0;
            if (snd.stb)
                stb_cnt++;
            if (nmi_sub)
                nmi_cnt++;
        end
        if (done && !finished) begin
            close_test();
            $display("Summary: %0d tests passed, %0d tests failed", passed_tests, failed_tests);
            finished = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* bubl_main_board.sv */
//////////////////////////////////////////////////////////////////////
// Main board top level
// Main port acknowledge, read data mux and block instances
//////////////////////////////////////////////////////////////////////
`default_nettype none

module bubl_main_board
    import bubl_pkg::*;
#(
    parameter int rom_aw  = 18,
    parameter int work_aw = 13
) (
    input  logic               clk24,
    input  logic               rst,
    input  game_t              game,
    // CPU buses
    input  wb_req_t            main_bus,
    output wb_rsp_t            main_rsp,
    input  wb_req_t            sub_bus,
    output wb_rsp_t            sub_rsp,
    // Program ROM
    output logic [rom_aw-1:0]  main_rom_addr,
    output logic               main_rom_cs,
    input  logic               main_rom_ok,
    input  logic [7:0]         main_rom_data,
    // Video
    output logic               vram_cs,
    output logic               pal_cs,
    output logic               cpu_we,
    input  logic [7:0]         vram_dout,
    input  logic [7:0]         pal_dout,
    // Sound
    output snd_t               snd,
    output logic               main_flag,
    input  logic [7:0]         main_latch,
    input  logic               snd_flag,
    input  logic               main_stb,
    // Misc
    output misc_t              misc,
    output logic               nmi_sub,
    input  cab_in_t            cab
);

    region_t    region;
    logic       reg_ack;
    logic       ack_d;
    logic [7:0] rd_q;
    logic       cab_sel_q;
    logic [7:0] sound_status;
    logic [7:0] cab_dout;
    wb_rsp_t    ram_rsp;

    bubl_main_decode #(.rom_aw(rom_aw)) u_decode (
        .game     (game),
        .main_bus (main_bus),
        .bank     (misc.bank),
        .region   (region),
        .rom_addr (main_rom_addr),
        .rom_cs   (main_rom_cs)
    );

    bubl_ctrl_regs u_ctrl (
        .clk24        (clk24),
        .rst          (rst),
        .game         (game),
        .main_bus     (main_bus),
        .region       (region),
        .wr_ack       (reg_ack),
        .main_stb     (main_stb),
        .misc         (misc),
        .snd          (snd),
        .main_flag    (main_flag),
        .nmi_sub      (nmi_sub),
        .sound_status (sound_status)
    );

    bubl_cabinet u_cab (
        .clk24    (clk24),
        .cab      (cab),
        .offset   (main_bus.adr[2:0]),
        .cab_dout (cab_dout)
    );

    bubl_work_ram #(.work_aw(work_aw)) u_work (
        .clk24    (clk24),
        .rst      (rst),
        .game     (game),
        .main_req (main_bus),
        .main_sel (region == reg_work),
        .sub_req  (sub_bus),
        .sub_sel  (sub_bus.cyc && sub_bus.stb),
        .main_rsp (ram_rsp),
        .sub_rsp  (sub_rsp)
    );

    assign vram_cs = region == reg_vram && main_bus.cyc && main_bus.stb;
    assign pal_cs  = region == reg_pal && main_bus.cyc && main_bus.stb;
    assign cpu_we  = main_bus.cyc && main_bus.stb && main_bus.we;

    //////////////////////////////////////////////////////////////////
    // Acknowledge for everything but work RAM

    always_comb begin
        ack_d = 1'b0;
        if (!reg_ack) begin
            if (region == reg_rom)
                ack_d = main_rom_cs && main_rom_ok;     // Wait for SDRAM data
            else if (region != reg_work)
                ack_d = main_bus.cyc && main_bus.stb;
        end
    end

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst)
            reg_ack <= 1'b0;
        else
            reg_ack <= ack_d;
    end

    // Registered read data
    always_ff @(posedge clk24) begin
        cab_sel_q <= region == reg_cab;
        case (region)
            reg_rom:   rd_q <= main_rom_data;
            reg_vram:  rd_q <= vram_dout;
            reg_pal:   rd_q <= pal_dout;
            reg_comm:  rd_q <= (game == game_tokio) ? COMM_STUB_TOKIO : OPEN_BUS;
            reg_sound: rd_q <= main_bus.adr[0] ? (sound_status | {7'd0, snd_flag})
                                               : main_latch;
            default:   rd_q <= OPEN_BUS;
        endcase
    end

    always_comb begin
        main_rsp.ack = reg_ack || ram_rsp.ack;
        if (ram_rsp.ack)
            main_rsp.dat = ram_rsp.dat;
        else if (cab_sel_q)
            main_rsp.dat = cab_dout;    // Already registered in the cabinet block
        else
            main_rsp.dat = rd_q;
    end

    ack_in_cycle: assert property (@(posedge clk24) disable iff (rst)
        main_rsp.ack |-> main_bus.cyc && main_bus.stb)
        else $error("Main port acked outside a bus cycle");

endmodule

`default_nettype wire

/* bubl_work_ram.sv */
//////////////////////////////////////////////////////////////////////
// Work RAM shared by the main and sub buses, with arbitration
//////////////////////////////////////////////////////////////////////
`default_nettype none

module bubl_work_ram
    import bubl_pkg::*;
#(
    parameter int work_aw = 13
) (
    input  logic    clk24,
    input  logic    rst,
    input  game_t   game,
    input  wb_req_t main_req,
    input  logic    main_sel,       // Main address decodes to work RAM
    input  wb_req_t sub_req,
    input  logic    sub_sel,        // Sub cycle active
    output wb_rsp_t main_rsp,
    output wb_rsp_t sub_rsp
);

    logic [7:0] mem [2**work_aw];
    logic [7:0] rd_q;

    logic    sub_win;
    logic    main_rq;
    logic    sub_rq;
    logic    sub_oob;
    logic    grant_main;
    logic    grant_sub;
    logic    busy;
    logic    owner;                 // 0 main, 1 sub
    logic    sub_prio;
    logic    oob_ack_q;
    wb_req_t gnt_req;

    // Sub window differs per game
    assign sub_win = (game == game_tokio) ? sub_req.adr[15:13] == 3'b100
                                          : sub_req.adr[15:13] == 3'b111;

    assign main_rq = main_sel && main_req.cyc && main_req.stb;
    assign sub_rq  = sub_sel && sub_win;
    assign sub_oob = sub_sel && !sub_win;

    // Main wins ties unless sub already lost once
    assign grant_sub  = !busy && sub_rq && (!main_rq || sub_prio);
    assign grant_main = !busy && main_rq && !grant_sub;
    assign gnt_req    = grant_sub ? sub_req : main_req;

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            owner     <= 1'b0;
            sub_prio  <= 1'b0;
            oob_ack_q <= 1'b0;
        end else begin
            busy      <= grant_main || grant_sub;   // Ack cycle follows the grant
            oob_ack_q <= sub_oob && !oob_ack_q;
            if (grant_main || grant_sub)
                owner <= grant_sub;
            if (grant_sub)
                sub_prio <= 1'b0;
            else if (grant_main && sub_rq)
                sub_prio <= 1'b1;
        end
    end

    // Single port, one access per grant
    always_ff @(posedge clk24) begin
        if (grant_main || grant_sub) begin
            if (gnt_req.we)
                mem[gnt_req.adr[work_aw-1:0]] <= gnt_req.dat;
            rd_q <= mem[gnt_req.adr[work_aw-1:0]];
        end
    end

    assign main_rsp.ack = busy && !owner;
    assign main_rsp.dat = rd_q;
    assign sub_rsp.ack  = (busy && owner) || oob_ack_q;
    assign sub_rsp.dat  = oob_ack_q ? OPEN_BUS : rd_q;

    // Sub loses to main, then is served in the next free slot
    sub_served_next: assert property (@(posedge clk24) disable iff (rst)
        grant_main && sub_rq |-> ##3 sub_rsp.ack)
        else $error("Sub port not served right after losing to the main port");

endmodule

`default_nettype wire

/* bubl_cabinet.sv */
//////////////////////////////////////////////////////////////////////
// Cabinet input port read mux, second game only
//////////////////////////////////////////////////////////////////////
`default_nettype none

module bubl_cabinet
    import bubl_pkg::*;
(
    input  logic        clk24,
    input  cab_in_t     cab,
    input  logic [2:0]  offset,
    output logic [7:0]  cab_dout
);

    // Joystick bits come out in board wiring order
    function automatic logic [7:0] player_byte(input logic start, input logic [5:0] joy);
        player_byte = {1'b1, start, joy[4], joy[5], joy[3], joy[2], joy[0], joy[1]};
    endfunction

    always_ff @(posedge clk24) begin
        case (offset)
            3'd3:    cab_dout <= cab.dip_a;
            3'd4:    cab_dout <= cab.dip_b;
            3'd5:    cab_dout <= {4'hF, cab.coin, 2'b11};
            3'd6:    cab_dout <= player_byte(cab.start[0], cab.joy1);
            3'd7:    cab_dout <= player_byte(cab.start[1], cab.joy2);
            default: cab_dout <= OPEN_BUS;
        endcase
    end

endmodule

`default_nettype wire

/* bubl_ctrl_regs.sv */
//////////////////////////////////////////////////////////////////////
// Miscellaneous control register and sound CPU handshake
//////////////////////////////////////////////////////////////////////
`default_nettype none

module bubl_ctrl_regs
    import bubl_pkg::*;
(
    input  logic        clk24,
    input  logic        rst,
    input  game_t       game,
    input  wb_req_t     main_bus,
    input  region_t     region,
    input  logic        wr_ack,         // Ack of the current main cycle
    input  logic        main_stb,
    output misc_t       misc,
    output snd_t        snd,
    output logic        main_flag,
    output logic        nmi_sub,
    output logic [7:0]  sound_status
);

    logic wr_en;
    logic rd_en;
    logic prev_stb;

    assign wr_en = wr_ack && main_bus.we;
    assign rd_en = wr_ack && !main_bus.we;

    //////////////////////////////////////////////////////////////////
    // Misc register

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            misc <= '0;                 // Blanked, sub CPU held in reset
        end else begin
            if (wr_en && region == reg_misc) begin
                if (game == game_tokio)
                    misc.bank <= main_bus.dat[2:0];
                else
                    misc.bank <= {~main_bus.dat[2], main_bus.dat[1:0]};
                misc.black_n <= main_bus.dat[6];
                if (game == game_bubble) begin
                    misc.sub_rst_n <= main_bus.dat[4];
                    misc.flip      <= main_bus.dat[7];
                end else begin
                    misc.sub_rst_n <= 1'b1;
                end
            end
            if (wr_en && region == reg_flip)
                misc.flip <= main_bus.dat[7];   // Separate window in the second game
        end
    end

    //////////////////////////////////////////////////////////////////
    // Sound CPU side

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            snd.latch <= 8'd0;
            snd.stb   <= 1'b0;
            snd.rstn  <= 1'b1;          // Sound CPU runs from power up
            nmi_sub   <= 1'b0;
        end else begin
            snd.stb <= wr_en && region == reg_sound && main_bus.adr[1:0] == 2'd0;
            nmi_sub <= wr_en && region == reg_nmi;
            if (wr_en && region == reg_sound) begin
                case (main_bus.adr[1:0])
                    2'd0:    snd.latch <= main_bus.dat;
                    2'd3:    snd.rstn  <= ~main_bus.dat[0];
                    default: ;
                endcase
            end
        end
    end

    // Main flag drops on a status read, returns on a sound strobe edge
    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            prev_stb  <= 1'b0;
            main_flag <= 1'b1;
        end else begin
            prev_stb <= main_stb;
            if (main_stb && !prev_stb)
                main_flag <= 1'b1;
            else if (rd_en && region == reg_sound)
                main_flag <= 1'b0;
        end
    end

    assign sound_status = {6'h3F, main_flag, 1'b0};    // Bit 0 filled at the top

    snd_stb_single: assert property (@(posedge clk24) disable iff (rst)
        snd.stb |=> !snd.stb)
        else $error("Sound strobe held for more than one cycle");

endmodule

`default_nettype wire

/* bubl_main_decode.sv */
//////////////////////////////////////////////////////////////////////
// Main-bus region decoder and banked program ROM address
//////////////////////////////////////////////////////////////////////
`default_nettype none

module bubl_main_decode
    import bubl_pkg::*;
#(
    parameter int rom_aw = 18
) (
    input  game_t              game,
    input  wb_req_t            main_bus,
    input  logic    [2:0]      bank,
    output region_t            region,
    output logic [rom_aw-1:0]  rom_addr,
    output logic               rom_cs
);

    logic [7:0]  page;
    logic        a7;
    logic        wr;
    logic [3:0]  rom_page;
    logic [17:0] banked_addr;

    assign page = main_bus.adr[15:8];
    assign a7   = main_bus.adr[7];
    assign wr   = main_bus.we;

    always_comb begin
        region = reg_none;
        if (main_bus.adr[15:14] != 2'b11) begin
            region = reg_rom;                           // 0000-BFFF
        end else if (main_bus.adr[15:13] == 3'b110) begin
            region = reg_vram;                          // C000-DFFF
        end else if (main_bus.adr[12:11] != 2'b11) begin
            region = reg_work;                          // E000-F7FF
        end else if (main_bus.adr[15:9] == 7'b1111_100) begin
            region = reg_pal;                           // F800-F9FF
        end else if (game == game_tokio) begin
            if (page == 8'hFC && !a7)
                region = reg_sound;
            else if (page == 8'hFA && a7)
                region = wr ? reg_misc : reg_none;
            else if (page == 8'hFA)
                region = wr ? reg_wdog : reg_cab;       // Cabinet shares the watchdog page
            else if (page == 8'hFB)
                region = !wr ? reg_none : (a7 ? reg_nmi : reg_flip);
            else if (main_bus.adr[15:9] == 7'b1111_111)
                region = reg_comm;
        end else begin
            if (page == 8'hFA)
                region = a7 ? reg_wdog : reg_sound;
            else if (page == 8'hFB && main_bus.adr[7:6] == 2'b01)
                region = wr ? reg_misc : reg_none;
            else if (page == 8'hFB && main_bus.adr[7:6] == 2'b00)
                region = wr ? reg_nmi : reg_none;
            else if (main_bus.adr[15:10] == 6'b1111_11)
                region = reg_comm;
        end
    end

    // Upper half of the CPU map is a 16 KB window into the banked pages
    assign rom_page    = {1'b0, bank} + BANK_BASE;
    assign banked_addr = {rom_page, main_bus.adr[13:0]};
    assign rom_addr    = main_bus.adr[15] ? rom_aw'(banked_addr)
                                          : rom_aw'(main_bus.adr[14:0]);
    assign rom_cs      = region == reg_rom && main_bus.cyc && main_bus.stb;

endmodule

`default_nettype wire

/* bubl_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types and constants for the main-board glue logic
// Bus structs, game and region enums, cabinet and control bundles
//////////////////////////////////////////////////////////////////////
`default_nettype none

package bubl_pkg;

    // Wishbone classic request from one CPU bus
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [ 7:0] dat;
    } wb_req_t;

    // Wishbone response back to the CPU bus
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb_rsp_t;

    typedef enum logic {
        game_bubble,
        game_tokio
    } game_t;

    // Decoded main-bus target
    typedef enum logic [3:0] {
        reg_rom, reg_vram, reg_pal, reg_work,
        reg_comm, reg_sound, reg_misc, reg_flip,
        reg_nmi, reg_wdog, reg_cab, reg_none
    } region_t;

    typedef struct packed {
        logic [1:0] start;      // Player start buttons
        logic [1:0] coin;
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic [7:0] dip_a;
        logic [7:0] dip_b;
    } cab_in_t;

    typedef struct packed {
        logic [2:0] bank;       // ROM page select
        logic       black_n;
        logic       flip;
        logic       sub_rst_n;
    } misc_t;

    typedef struct packed {
        logic [7:0] latch;
        logic       stb;
        logic       rstn;       // Sound CPU out of reset when high
    } snd_t;

    localparam logic [3:0] BANK_BASE       = 4'd2;     // First banked 16 KB page
    localparam logic [7:0] OPEN_BUS        = 8'hFF;
    localparam logic [7:0] COMM_STUB_TOKIO = 8'hBF;

endpackage

`default_nettype wire
